/* sources.f */
src/clk_rst_pkg.sv
src/reset_sync.sv
src/rtc_divider.sv
src/div_ctrl.sv
src/clk_div_counter.sv
src/board_clk_rst.sv
bench/tb_clk_gen.sv
bench/tb_board_clk_rst.sv

/* bench/tb_board_clk_rst.sv */
// Testbench for the board clock and reset block
// Directed tests for reset release, the RTC clock, the PHY clock divider
// with its valid/ready reprogramming port, and the test-mode bypass.

`default_nettype none

module tb_board_clk_rst;

  localparam int ClkPeriod      = 40;
  localparam int MaxRatio       = 15;
  localparam int RtcPeriod      = 10;
  localparam int NumRandom      = 4;
  // Random, back-pressure pair and minimum-ratio requests
  localparam int NumRequests    = NumRandom + 2 + 4;
  localparam int MeasureLimit   = 2 * MaxRatio + 2;
  localparam int HandshakeLimit = 2 * MaxRatio + 4;
  localparam int TestCycles     = 30 + 6 * RtcPeriod + NumRequests * (4 * MaxRatio + 2);
  localparam int Timeout        = 2 * TestCycles * ClkPeriod;
  localparam bit SelRtc         = 1'b0;
  localparam bit SelHyp         = 1'b1;

  logic                  clk_10;
  logic                  gen_rst_n;
  logic                  tb_rst_n;
  logic                  rst_n;
  logic                  test_mode_i;
  logic                  div_valid_i;
  clk_rst_pkg::div_val_t div_i;
  logic                  div_ready_o;
  logic                  sys_rst_n_o;
  logic                  rtc_clk_o;
  logic                  hyp_clk_o;

  int                    val_errs;
  int                    proto_errs;
  integer                seed;
  clk_rst_pkg::div_val_t cur_ratio;

  tb_clk_gen tb_clk_gen_inst (
    .clk_o   ( clk_10    ),
    .rst_n_o ( gen_rst_n )
  );

  // Board reset from the generator, plus a later pulse for test mode
  assign rst_n = gen_rst_n & tb_rst_n;

  board_clk_rst board_clk_rst_inst (
    .clk_10      ( clk_10      ),
    .rst_n       ( rst_n       ),
    .test_mode_i ( test_mode_i ),
    .div_valid_i ( div_valid_i ),
    .div_i       ( div_i       ),
    .div_ready_o ( div_ready_o ),
    .sys_rst_n_o ( sys_rst_n_o ),
    .rtc_clk_o   ( rtc_clk_o   ),
    .hyp_clk_o   ( hyp_clk_o   )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks and helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected %h, got %h", name, exp, act);
      val_errs++;
    end
  endtask

  task automatic check_div(input string name, input clk_rst_pkg::div_val_t exp,
                           input clk_rst_pkg::div_val_t act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected %h, got %h", name, exp, act);
      val_errs++;
    end
  endtask

  function automatic logic clk_sample(input bit sel);
    return sel ? hyp_clk_o : rtc_clk_o;
  endfunction

  function automatic clk_rst_pkg::div_val_t random_ratio();
    int unsigned r;
    r = $random(seed);
    return clk_rst_pkg::div_val_t'(2 + r % 14);
  endfunction

  // Requests below the minimum are raised to it
  function automatic clk_rst_pkg::div_val_t expected_ratio(input clk_rst_pkg::div_val_t req);
    return (req < clk_rst_pkg::DivMin) ? clk_rst_pkg::DivMin : req;
  endfunction

  task automatic outputs_in_reset();
    check_bit("sys_rst_n_o", 1'b0, sys_rst_n_o);
    check_bit("rtc_clk_o", 1'b0, rtc_clk_o);
    check_bit("hyp_clk_o", 1'b0, hyp_clk_o);
    check_bit("div_ready_o", 1'b0, div_ready_o);
  endtask

  // Period and high phase between two rising edges, sampled on falling edges
  task automatic check_clock(input bit sel, input string name,
                             input clk_rst_pkg::div_val_t exp_per,
                             input clk_rst_pkg::div_val_t exp_high);
    int   per;
    int   high;
    int   n;
    logic prev;
    bit   found;
    found = 1'b0;
    prev  = clk_sample(sel);
    for (n = 0; n < MeasureLimit && !found; n++) begin
      @(negedge clk_10);
      found = clk_sample(sel) && !prev;
      prev  = clk_sample(sel);
    end
    if (!found) begin
      $display("No rising edge seen on %s within %0d cycles", name, MeasureLimit);
      proto_errs++;
    end else begin
      per   = 1;
      high  = 1;
      found = 1'b0;
      while (!found && per <= MaxRatio) begin
        @(negedge clk_10);
        if (clk_sample(sel) && !prev) begin
          found = 1'b1;
        end else begin
          per++;
          if (clk_sample(sel)) begin
            high++;
          end
        end
        prev = clk_sample(sel);
      end
      if (!found) begin
        $display("Second rising edge on %s never came within %0d cycles", name, MaxRatio);
        proto_errs++;
      end else begin
        check_div({name, " period"}, exp_per, clk_rst_pkg::div_val_t'(per));
        check_div({name, " high phase"}, exp_high, clk_rst_pkg::div_val_t'(high));
      end
    end
  endtask

  // Hold valid until ready, then drop it after the transfer edge
  task automatic send_request(input clk_rst_pkg::div_val_t val, output int waited,
                              output bit ok);
    ok          = 1'b0;
    waited      = 0;
    div_valid_i = 1'b1;
    div_i       = val;
    while (!ok && waited <= HandshakeLimit) begin
      if (div_ready_o === 1'b1) begin
        ok = 1'b1;
      end else begin
        @(negedge clk_10);
        waited++;
      end
    end
    if (ok) begin
      @(negedge clk_10);
    end else begin
      $display("Request of %0d was never accepted, div_ready_o stayed low", val);
      proto_errs++;
    end
    div_valid_i = 1'b0;
    div_i       = '0;
    if (ok) begin
      check_bit("div_ready_o", 1'b0, div_ready_o);
    end
  endtask

  task automatic wait_ready(input int limit, output bit ok);
    int cycles;
    cycles = 0;
    while (div_ready_o !== 1'b1 && cycles < limit) begin
      @(negedge clk_10);
      cycles++;
    end
    ok = (div_ready_o === 1'b1);
    if (!ok) begin
      $display("div_ready_o did not return high within %0d cycles", limit);
      proto_errs++;
    end
  endtask

  task automatic program_and_check(input clk_rst_pkg::div_val_t req);
    clk_rst_pkg::div_val_t old;
    clk_rst_pkg::div_val_t exp;
    int                    waited;
    bit                    ok;
    old = cur_ratio;
    exp = expected_ratio(req);
    send_request(req, waited, ok);
    if (ok) begin
      wait_ready(int'(old), ok);
      if (ok) begin
        check_clock(SelHyp, "hyp_clk_o", exp, exp >> 1);
      end
    end
    cur_ratio = exp;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic verify_reset();
    bit ok;
    @(negedge clk_10);
    outputs_in_reset();
    wait (rst_n === 1'b1);
    // First edge after release still holds reset
    @(posedge clk_10);
    @(negedge clk_10);
    outputs_in_reset();
    @(negedge clk_10);
    check_bit("sys_rst_n_o", 1'b1, sys_rst_n_o);
    wait_ready(4, ok);
  endtask

  task automatic rtc_clock_period();
    int n;
    for (n = 0; n < 3; n++) begin
      check_clock(SelRtc, "rtc_clk_o", clk_rst_pkg::div_val_t'(RtcPeriod),
                  clk_rst_pkg::div_val_t'(RtcPeriod / 2));
    end
  endtask

  task automatic default_phy_clock();
    check_clock(SelHyp, "hyp_clk_o", clk_rst_pkg::HypClkDivDefault,
                clk_rst_pkg::HypClkDivDefault >> 1);
  endtask

  task automatic reprogram_random();
    int n;
    for (n = 0; n < NumRandom; n++) begin
      program_and_check(random_ratio());
    end
  endtask

  // Second request arrives while the first is still pending
  task automatic hold_while_busy();
    clk_rst_pkg::div_val_t first;
    clk_rst_pkg::div_val_t second;
    clk_rst_pkg::div_val_t old;
    int                    waited;
    bit                    ok;
    first  = random_ratio();
    second = random_ratio();
    old    = cur_ratio;
    send_request(first, waited, ok);
    if (ok) begin
      send_request(second, waited, ok);
      if (ok && (waited < 1 || waited > int'(old))) begin
        $display("Held request waited %0d cycles, outside 1 to %0d", waited, old);
        proto_errs++;
      end
      if (ok) begin
        wait_ready(int'(expected_ratio(first)), ok);
        if (ok) begin
          check_clock(SelHyp, "hyp_clk_o", expected_ratio(second),
                      expected_ratio(second) >> 1);
        end
      end
    end
    cur_ratio = expected_ratio(second);
  endtask

  task automatic clamp_min_ratio();
    program_and_check(clk_rst_pkg::div_val_t'(9));
    program_and_check(clk_rst_pkg::div_val_t'(0));
    program_and_check(clk_rst_pkg::div_val_t'(7));
    program_and_check(clk_rst_pkg::div_val_t'(1));
  endtask

  task automatic bypass_in_test_mode();
    bit ok;
    @(negedge clk_10);
    test_mode_i = 1'b1;
    tb_rst_n    = 1'b0;
    #(ClkPeriod / 4);
    outputs_in_reset();
    @(negedge clk_10);
    tb_rst_n = 1'b1;
    #(ClkPeriod / 4);
    check_bit("sys_rst_n_o", 1'b1, sys_rst_n_o);
    repeat (3) @(negedge clk_10);
    test_mode_i = 1'b0;
    wait_ready(4, ok);
    // Ratio falls back to the default after reset
    cur_ratio = clk_rst_pkg::HypClkDivDefault;
    default_phy_clock();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    test_mode_i = 1'b0;
    div_valid_i = 1'b0;
    div_i       = '0;
    tb_rst_n    = 1'b1;
    val_errs    = 0;
    proto_errs  = 0;
    seed        = 32'he47;
    cur_ratio   = clk_rst_pkg::HypClkDivDefault;

    verify_reset();
    rtc_clock_period();
    default_phy_clock();
    reprogram_random();
    hold_while_busy();
    clamp_min_ratio();
    bypass_in_test_mode();

    $display("Summary: %0d value errors, %0d protocol errors", val_errs, proto_errs);
    if (val_errs + proto_errs == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin
    #(Timeout);
    $display("Timeout after %0d time units, tests did not complete", Timeout);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/tb_clk_gen.sv */
// Testbench clock and reset source
// Free-running clk_10 and a board reset held low for the first cycles.

`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam int ClkPeriod = 40;
  localparam int RstCycles = 2;

  initial begin
    clk_o = 1'b0;
    forever #(ClkPeriod / 2) clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RstCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

/* src/board_clk_rst.sv */
// Board clock and reset shell
// Synchronised system reset, 1 MHz RTC clock and the programmable
// memory PHY clock, all generated from clk_10.

`default_nettype none

module board_clk_rst (
  input  wire logic                  clk_10,
  input  wire logic                  rst_n,
  input  wire logic                  test_mode_i,
  input  wire logic                  div_valid_i,
  input  wire clk_rst_pkg::div_val_t div_i,
  output logic                       div_ready_o,
  output logic                       sys_rst_n_o,
  output logic                       rtc_clk_o,
  output logic                       hyp_clk_o
);

  logic                   sys_rst_n;
  logic                   period_end;
  clk_rst_pkg::div_load_t div_load;

  reset_sync reset_sync_inst (
    .clk_10      ( clk_10      ),
    .rst_n       ( rst_n       ),
    .test_mode_i ( test_mode_i ),
    .rst_n_o     ( sys_rst_n   )
  );

  assign sys_rst_n_o = sys_rst_n;

  rtc_divider rtc_divider_inst (
    .clk_10    ( clk_10    ),
    .rst_n     ( sys_rst_n ),
    .rtc_clk_o ( rtc_clk_o )
  );

  ////////////////////////////////////////////////////////////////////////////
  // PHY clock divider
  ////////////////////////////////////////////////////////////////////////////

  div_ctrl div_ctrl_inst (
    .clk_10       ( clk_10      ),
    .rst_n        ( sys_rst_n   ),
    .div_valid_i  ( div_valid_i ),
    .div_i        ( div_i       ),
    .div_ready_o  ( div_ready_o ),
    .period_end_i ( period_end  ),
    .load_o       ( div_load    )
  );

  clk_div_counter clk_div_counter_inst (
    .clk_10       ( clk_10     ),
    .rst_n        ( sys_rst_n  ),
    .load_i       ( div_load   ),
    .period_end_o ( period_end ),
    .hyp_clk_o    ( hyp_clk_o  )
  );

endmodule

`default_nettype wire

/* src/clk_div_counter.sv */
// PHY clock period counter
// Holds the active integer ratio and counts each period of it, giving a
// registered divided clock and an end-of-period flag for reloads.

`default_nettype none

module clk_div_counter (
  input  wire logic                   clk_10,
  input  wire logic                   rst_n,
  input  wire clk_rst_pkg::div_load_t load_i,
  output logic                        period_end_o,
  output logic                        hyp_clk_o
);

  clk_rst_pkg::div_val_t div_d, div_q;
  clk_rst_pkg::div_val_t cnt_d, cnt_q;
  logic                  hyp_clk_q;

  // Last cycle of the current period
  assign period_end_o = (cnt_q == clk_rst_pkg::div_val_t'(div_q - 1'b1));

  always_comb begin
    div_d = div_q;
    cnt_d = cnt_q + 1'b1;
    if (period_end_o) begin
      cnt_d = '0;
      // New ratio takes over from count 0
      if (load_i.load) begin
        div_d = load_i.value;
      end
    end
  end

  // Reset parks the count on the last cycle, clock low
  always_ff @(posedge clk_10 or negedge rst_n) begin
    if (!rst_n) begin
      div_q     <= clk_rst_pkg::HypClkDivDefault;
      cnt_q     <= clk_rst_pkg::div_val_t'(clk_rst_pkg::HypClkDivDefault - 1'b1);
      hyp_clk_q <= 1'b0;
    end else begin
      div_q     <= div_d;
      cnt_q     <= cnt_d;
      // High for floor(N/2) cycles of each period
      hyp_clk_q <= (cnt_d < (div_d >> 1));
    end
  end

  assign hyp_clk_o = hyp_clk_q;

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  a_cnt_in_period : assert property (
    @(posedge clk_10) disable iff (!rst_n)
    cnt_q < div_q
  );

endmodule

`default_nettype wire

/* src/div_ctrl.sv */
// PHY clock divider controller
// Takes new ratios over a valid/ready port, clamps them to the minimum and
// holds them until the period counter reaches the end of its period.
// One request is in flight at a time.

`default_nettype none

module div_ctrl (
  input  wire logic                  clk_10,
  input  wire logic                  rst_n,
  input  wire logic                  div_valid_i,
  input  wire clk_rst_pkg::div_val_t div_i,
  output logic                       div_ready_o,
  input  wire logic                  period_end_i,
  output clk_rst_pkg::div_load_t     load_o
);

  clk_rst_pkg::div_state_e state_d, state_q;
  clk_rst_pkg::div_val_t   pend_d, pend_q;
  logic                    ready_q;
  logic                    accept;

  // Transfer on valid and ready
  assign accept = div_valid_i & ready_q;

  // Clamp to the smallest legal ratio
  always_comb begin
    if (div_i < clk_rst_pkg::DivMin) begin
      pend_d = clk_rst_pkg::DivMin;
    end else begin
      pend_d = div_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    load_o.load  = 1'b0;
    load_o.value = pend_q;
    case (state_q)
      clk_rst_pkg::DIV_IDLE: begin
        if (accept) begin
          state_d = clk_rst_pkg::DIV_WAIT_EDGE;
        end
      end
      clk_rst_pkg::DIV_WAIT_EDGE: begin
        // Reload only on the last cycle of a period
        if (period_end_i) begin
          load_o.load = 1'b1;
          state_d     = clk_rst_pkg::DIV_IDLE;
        end
      end
      default: begin
        state_d = clk_rst_pkg::DIV_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_10 or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= clk_rst_pkg::DIV_IDLE;
      ready_q <= 1'b0;
    end else begin
      state_q <= state_d;
      ready_q <= (state_d == clk_rst_pkg::DIV_IDLE);
    end
  end

  always_ff @(posedge clk_10) begin
    if (accept) begin
      pend_q <= pend_d;
    end
  end

  assign div_ready_o = ready_q;

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  a_load_min : assert property (
    @(posedge clk_10) disable iff (!rst_n)
    load_o.load |-> (load_o.value >= clk_rst_pkg::DivMin)
  );

endmodule

`default_nettype wire

/* src/rtc_divider.sv */
// Real-time clock divider
// Turns clk_10 into the 1 MHz RTC clock with a prescale counter and a
// toggle flop. Both are held low in reset.

`default_nettype none

module rtc_divider (
  input  wire logic clk_10,
  input  wire logic rst_n,
  output logic      rtc_clk_o
);

  clk_rst_pkg::rtc_cnt_t cnt_d, cnt_q;
  logic                  rtc_clk_d, rtc_clk_q;

  always_comb begin
    cnt_d     = cnt_q + 1'b1;
    rtc_clk_d = rtc_clk_q;
    // Wrap and flip phase
    if (cnt_q == clk_rst_pkg::RtcHalfPeriod) begin
      cnt_d     = '0;
      rtc_clk_d = ~rtc_clk_q;
    end
  end

  always_ff @(posedge clk_10 or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q     <= '0;
      rtc_clk_q <= 1'b0;
    end else begin
      cnt_q     <= cnt_d;
      rtc_clk_q <= rtc_clk_d;
    end
  end

  assign rtc_clk_o = rtc_clk_q;

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Prescaler stays inside one half period
  a_cnt_bound : assert property (
    @(posedge clk_10) disable iff (!rst_n)
    cnt_q <= clk_rst_pkg::RtcHalfPeriod
  );

endmodule

`default_nettype wire

/* src/reset_sync.sv */
// Reset synchroniser
// Asserts asynchronously and releases on clk_10 through a short flop chain.
// Test mode hands the board reset straight through.

`default_nettype none

module reset_sync (
  input  wire logic clk_10,
  input  wire logic rst_n,
  input  wire logic test_mode_i,
  output logic      rst_n_o
);

  logic [clk_rst_pkg::RstSyncStages-1:0] sync_q;

  // Shift ones in after release, clear whole chain on assert
  always_ff @(posedge clk_10 or negedge rst_n) begin
    if (!rst_n) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[clk_rst_pkg::RstSyncStages-2:0], 1'b1};
    end
  end

  // Bypass for scan and test
  always_comb begin
    if (test_mode_i) begin
      rst_n_o = rst_n;
    end else begin
      rst_n_o = sync_q[clk_rst_pkg::RstSyncStages-1];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Release never runs ahead of the board reset
  a_no_early_release : assert property (
    @(posedge clk_10) $rose(rst_n_o) |-> rst_n
  );

endmodule

`default_nettype wire

/* src/clk_rst_pkg.sv */
// Clock and reset shell package
// Widths, reset defaults, divider types and the controller state encoding
// shared by the board clock and reset block.

`default_nettype none

package clk_rst_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths and defaults
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned DivWidth      = 4;
  localparam int unsigned RtcCntWidth   = 5;
  localparam int unsigned RstSyncStages = 2;

  // Ratio in clk_10 cycles
  typedef logic [DivWidth-1:0] div_val_t;

  // RTC prescaler count
  typedef logic [RtcCntWidth-1:0] rtc_cnt_t;

  localparam div_val_t HypClkDivDefault = div_val_t'(2);
  localparam div_val_t DivMin           = div_val_t'(2);

  // 10 MHz in, toggle every 5 cycles, 1 MHz out
  localparam rtc_cnt_t RtcHalfPeriod = rtc_cnt_t'(4);

  ////////////////////////////////////////////////////////////////////////////
  // Divider control
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic {
    DIV_IDLE,
    DIV_WAIT_EDGE
  } div_state_e;

  // Reload command to the period counter
  typedef struct packed {
    logic     load;
    div_val_t value;
  } div_load_t;

endpackage

`default_nettype wire
